//--- src/drac_pkg.sv
// drac_pkg: shared types, instruction formats and constants for the decode front end
package drac_pkg;

    localparam int QUEUE_DEPTH = 4;  // Entries in the instruction queue

    typedef logic [63:0] bus64_t;

    localparam bus64_t RESET_PC = 64'h100;  // First fetch address after reset

    // Major opcodes of the RV64I base set that this front end recognises
    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_ALU_I   = 7'b0010011,
        OP_ALU_I_W = 7'b0011011,
        OP_ALU     = 7'b0110011,
        OP_ALU_W   = 7'b0111011,
        OP_SYSTEM  = 7'b1110011
    } op_e;

    typedef enum logic [2:0] {
        F3_PRIV   = 3'b000,  // ECALL, EBREAK, xRET and WFI
        F3_CSRRW  = 3'b001,
        F3_CSRRS  = 3'b010,
        F3_CSRRC  = 3'b011,
        F3_CSRRWI = 3'b101,
        F3_CSRRSI = 3'b110,
        F3_CSRRCI = 3'b111
    } f3_system_e;

    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JUMP,
        CLASS_UPPER,
        CLASS_CSR,
        CLASS_ILLEGAL
    } instr_class_e;

    // Format views, all 32 bits wide so they overlay in the union below
    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        op_e        opcode;
    } common_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        op_e         opcode;
    } itype_fmt_t;

    typedef struct packed {
        logic [6:0] imm5;   // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] imm0;   // imm[4:0]
        op_e        opcode;
    } stype_fmt_t;

    typedef struct packed {
        logic       imm12;  // imm[12], also the sign
        logic [5:0] imm5;   // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [3:0] imm1;   // imm[4:1]
        logic       imm11;  // imm[11]
        op_e        opcode;
    } btype_fmt_t;

    typedef struct packed {
        logic [19:0] imm;   // imm[31:12]
        logic [4:0]  rd;
        op_e         opcode;
    } utype_fmt_t;

    typedef struct packed {
        logic       imm20;  // imm[20], also the sign
        logic [9:0] imm1;   // imm[10:1]
        logic       imm11;  // imm[11]
        logic [7:0] imm12;  // imm[19:12]
        logic [4:0] rd;
        op_e        opcode;
    } jtype_fmt_t;

    typedef union packed {
        common_fmt_t common;
        itype_fmt_t  itype;
        stype_fmt_t  stype;
        btype_fmt_t  btype;
        utype_fmt_t  utype;
        jtype_fmt_t  jtype;
    } instruction_t;

    // What fetch produces and the queue stores
    typedef struct packed {
        bus64_t       pc;
        instruction_t instr;
    } fetch_item_t;

    typedef struct packed {
        bus64_t       pc;
        instruction_t instr;
        instr_class_e iclass;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        bus64_t       imm;
    } decode_out_t;

    typedef struct packed {
        logic   valid;
        bus64_t target;
    } redirect_t;

endpackage

//--- src/fetch_stage.sv
// fetch_stage: tags incoming instruction words with the program counter and applies redirects
module fetch_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   instr_valid_i,
    input  drac_pkg::instruction_t instr_i,
    input  logic                   queue_full_i,
    input  drac_pkg::redirect_t    redirect_i,
    output logic                   push_o,
    output drac_pkg::fetch_item_t  item_o
);

    drac_pkg::bus64_t pc_q;  // Address of the next word to be accepted
    logic             accept;

    // A word is taken only when the queue has room and no redirect is pending
    assign accept = instr_valid_i && !queue_full_i && !redirect_i.valid;

    assign push_o       = accept;
    assign item_o.pc    = pc_q;
    assign item_o.instr = instr_i;

    // Redirect has priority over the sequential advance
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= drac_pkg::RESET_PC;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.target;  // Strobe in this cycle is dropped
        end else if (accept) begin
            pc_q <= pc_q + 64'd4;
        end
    end

endmodule

//--- src/instr_queue.sv
// instr_queue: circular FIFO of tagged instructions between fetch and decode, with flush
module instr_queue (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  push_i,
    input  drac_pkg::fetch_item_t item_i,
    input  logic                  pop_i,
    input  logic                  flush_i,
    output drac_pkg::fetch_item_t head_o,
    output logic                  empty_o,
    output logic                  full_o
);

    drac_pkg::fetch_item_t                         mem_q [drac_pkg::QUEUE_DEPTH];
    logic [$clog2(drac_pkg::QUEUE_DEPTH)-1:0]      rd_ptr_q;
    logic [$clog2(drac_pkg::QUEUE_DEPTH)-1:0]      wr_ptr_q;
    logic [$clog2(drac_pkg::QUEUE_DEPTH + 1)-1:0]  count_q;  // Number of stored entries

    // Pointer increment with wrap at the last entry
    function automatic logic [$clog2(drac_pkg::QUEUE_DEPTH)-1:0] ptr_inc(
        input logic [$clog2(drac_pkg::QUEUE_DEPTH)-1:0] ptr
    );
        if (int'(ptr) == drac_pkg::QUEUE_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Fetch never pushes into a full queue so every push finds a free entry
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= item_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // Flush wins over any push or pop in the same cycle
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Idle, or push and pop together
            endcase
        end
    end

    assign head_o  = mem_q[rd_ptr_q];
    assign empty_o = (count_q == '0);
    assign full_o  = (int'(count_q) == drac_pkg::QUEUE_DEPTH);

endmodule

//--- src/immediate.sv
// immediate: builds the 64-bit immediate of an instruction from its opcode and funct3
module immediate (
    input  drac_pkg::instruction_t instr_i,
    output drac_pkg::bus64_t       imm_o
);

    logic             sign;  // Bit 31 is the sign in every format
    drac_pkg::bus64_t imm_itype;
    drac_pkg::bus64_t imm_stype;
    drac_pkg::bus64_t imm_btype;
    drac_pkg::bus64_t imm_utype;
    drac_pkg::bus64_t imm_jtype;
    drac_pkg::bus64_t imm_csr;

    assign sign = instr_i.itype.imm[11];

    assign imm_itype = {{52{sign}}, instr_i.itype.imm};
    assign imm_stype = {{52{sign}}, instr_i.stype.imm5, instr_i.stype.imm0};

    // Branch and jump offsets are in halfwords, so bit 0 is always zero
    assign imm_btype = {{52{sign}}, instr_i.btype.imm11, instr_i.btype.imm5,
                        instr_i.btype.imm1, 1'b0};
    assign imm_jtype = {{44{sign}}, instr_i.jtype.imm12, instr_i.jtype.imm11,
                        instr_i.jtype.imm1, 1'b0};

    assign imm_utype = {{32{sign}}, instr_i.utype.imm, 12'b0};

    // CSR immediate forms carry a 5-bit unsigned value in the rs1 field
    assign imm_csr = {59'b0, instr_i.common.rs1};

    always_comb begin
        case (instr_i.common.opcode)
            drac_pkg::OP_LUI,
            drac_pkg::OP_AUIPC: begin
                imm_o = imm_utype;
            end
            drac_pkg::OP_JAL: begin
                imm_o = imm_jtype;
            end
            drac_pkg::OP_JALR,
            drac_pkg::OP_LOAD,
            drac_pkg::OP_ALU_I,
            drac_pkg::OP_ALU_I_W: begin
                imm_o = imm_itype;
            end
            drac_pkg::OP_BRANCH: imm_o = imm_btype;
            drac_pkg::OP_STORE:  imm_o = imm_stype;
            drac_pkg::OP_SYSTEM: begin
                case (instr_i.common.func3)
                    drac_pkg::F3_CSRRWI,
                    drac_pkg::F3_CSRRSI,
                    drac_pkg::F3_CSRRCI: imm_o = imm_csr;
                    default:             imm_o = '0;  // Register CSR forms and PRIV
                endcase
            end
            default: begin
                imm_o = '0;  // Register-register ALU and unknown opcodes
            end
        endcase
    end

endmodule

//--- src/decode_stage.sv
// decode_stage: pops the instruction queue, classifies each word and resolves JAL redirects
module decode_stage (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  empty_i,
    input  drac_pkg::fetch_item_t head_i,
    input  logic                  stall_i,
    output logic                  pop_o,
    output drac_pkg::redirect_t   redirect_o,
    output logic                  dec_valid_o,
    output drac_pkg::decode_out_t dec_o
);

    drac_pkg::bus64_t       imm;
    drac_pkg::instr_class_e iclass;
    drac_pkg::decode_out_t  decoded;
    logic                   is_jal;

    logic                   dec_valid_q;
    drac_pkg::decode_out_t  dec_q;
    logic                   redirect_valid_q;
    drac_pkg::bus64_t       redirect_target_q;

    immediate i_immediate (
        .instr_i (head_i.instr),
        .imm_o   (imm)
    );

    // No pop while a redirect is pending since the queue is flushed on the next edge
    assign pop_o = !empty_i && !stall_i && !redirect_valid_q;

    always_comb begin
        case (head_i.instr.common.opcode)
            drac_pkg::OP_LUI,
            drac_pkg::OP_AUIPC:    iclass = drac_pkg::CLASS_UPPER;
            drac_pkg::OP_JAL,
            drac_pkg::OP_JALR:     iclass = drac_pkg::CLASS_JUMP;
            drac_pkg::OP_BRANCH:   iclass = drac_pkg::CLASS_BRANCH;
            drac_pkg::OP_LOAD:     iclass = drac_pkg::CLASS_LOAD;
            drac_pkg::OP_STORE:    iclass = drac_pkg::CLASS_STORE;
            drac_pkg::OP_ALU_I,
            drac_pkg::OP_ALU_I_W,
            drac_pkg::OP_ALU,
            drac_pkg::OP_ALU_W:    iclass = drac_pkg::CLASS_ALU;
            drac_pkg::OP_SYSTEM: begin
                case (head_i.instr.common.func3)
                    drac_pkg::F3_CSRRW,
                    drac_pkg::F3_CSRRS,
                    drac_pkg::F3_CSRRC,
                    drac_pkg::F3_CSRRWI,
                    drac_pkg::F3_CSRRSI,
                    drac_pkg::F3_CSRRCI: iclass = drac_pkg::CLASS_CSR;
                    drac_pkg::F3_PRIV:   iclass = drac_pkg::CLASS_ALU;
                    default:             iclass = drac_pkg::CLASS_ALU;  // Reserved funct3 4
                endcase
            end
            default:               iclass = drac_pkg::CLASS_ILLEGAL;
        endcase
    end

    assign is_jal = (head_i.instr.common.opcode == drac_pkg::OP_JAL);

    assign decoded.pc     = head_i.pc;
    assign decoded.instr  = head_i.instr;
    assign decoded.iclass = iclass;
    assign decoded.rd     = head_i.instr.common.rd;
    assign decoded.rs1    = head_i.instr.common.rs1;
    assign decoded.rs2    = head_i.instr.common.rs2;
    assign decoded.imm    = imm;

    // Each pop captures the decoded item and its jump target
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            dec_q             <= decoded;
            redirect_target_q <= head_i.pc + imm;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_q      <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            dec_valid_q      <= pop_o;
            redirect_valid_q <= pop_o && is_jal;  // Drops after one cycle since pop is blocked
        end
    end

    assign dec_valid_o       = dec_valid_q;
    assign dec_o             = dec_q;
    assign redirect_o.valid  = redirect_valid_q;
    assign redirect_o.target = redirect_target_q;

endmodule

//--- src/frontend_top.sv
// frontend_top: fetch, instruction queue and decode of the in-order front end
module frontend_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   instr_valid_i,
    input  drac_pkg::instruction_t instr_i,
    input  logic                   stall_i,
    output logic                   full_o,
    output logic                   dec_valid_o,
    output drac_pkg::decode_out_t  dec_o
);

    logic                  push;
    drac_pkg::fetch_item_t fetch_item;
    logic                  pop;
    drac_pkg::fetch_item_t head_item;
    logic                  queue_empty;
    logic                  queue_full;
    drac_pkg::redirect_t   redirect;  // From decode back to fetch and the queue

    fetch_stage i_fetch_stage (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .queue_full_i  (queue_full),
        .redirect_i    (redirect),
        .push_o        (push),
        .item_o        (fetch_item)
    );

    instr_queue i_instr_queue (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .push_i   (push),
        .item_i   (fetch_item),
        .pop_i    (pop),
        .flush_i  (redirect.valid),
        .head_o   (head_item),
        .empty_o  (queue_empty),
        .full_o   (queue_full)
    );

    decode_stage i_decode_stage (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .empty_i     (queue_empty),
        .head_i      (head_item),
        .stall_i     (stall_i),
        .pop_o       (pop),
        .redirect_o  (redirect),
        .dec_valid_o (dec_valid_o),
        .dec_o       (dec_o)
    );

    assign full_o = queue_full;

endmodule

//--- verification/tb_rv_encode.svh
// Testbench helpers: RISC-V instruction encoders, reference immediate model and LFSR source
`ifndef TB_RV_ENCODE_SVH
`define TB_RV_ENCODE_SVH

logic [31:0] lfsr_q = 32'h55157ab2;  // Fibonacci LFSR state, taps 32 22 2 1

// Returns n fresh bits, one LFSR step per bit
function automatic logic [31:0] lfsr_bits(input int n);
    logic        fb;
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        bits   = {bits[30:0], fb};
    end
    return bits;
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], drac_pkg::OP_STORE};
endfunction

// Bit 0 of the branch offset is not encoded
function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], drac_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [19:0] imm);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, drac_pkg::OP_JAL};
endfunction

// Immediate as the ISA defines it for each format, taken straight from the raw word
function automatic drac_pkg::bus64_t ref_imm(input logic [31:0] w);
    drac_pkg::bus64_t imm;
    imm = '0;
    case (w[6:0])
        drac_pkg::OP_LUI, drac_pkg::OP_AUIPC: imm = {{32{w[31]}}, w[31:12], 12'h000};
        drac_pkg::OP_JAL:    imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        drac_pkg::OP_BRANCH: imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        drac_pkg::OP_STORE:  imm = {{52{w[31]}}, w[31:25], w[11:7]};
        drac_pkg::OP_JALR, drac_pkg::OP_LOAD,
        drac_pkg::OP_ALU_I, drac_pkg::OP_ALU_I_W: imm = {{52{w[31]}}, w[31:20]};
        drac_pkg::OP_SYSTEM: begin
            if (w[14]) begin
                imm = (w[13:12] != 2'b00) ? {59'd0, w[19:15]} : '0;  // funct3 4 is reserved
            end
        end
        default: imm = '0;
    endcase
    return imm;
endfunction

`endif

//--- verification/tb_frontend.sv
// tb_frontend: directed testbench for the fetch, queue and decode front end
module tb_frontend;

    logic                   clk;
    logic                   arst_n;
    logic                   instr_valid;
    drac_pkg::instruction_t instr;
    logic                   stall;
    logic                   full;
    logic                   dec_valid;
    drac_pkg::decode_out_t  dec;
    drac_pkg::bus64_t       exp_pc;  // Address the next accepted word should carry

    localparam int WAIT_LIMIT = 16;

    `include "tb_rv_encode.svh"

    frontend_top i_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .stall_i       (stall),
        .full_o        (full),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #5;  // Drive and sample away from the edge
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_bus64(input string name, input drac_pkg::bus64_t exp_v,
                                 input drac_pkg::bus64_t act_v);
        if (exp_v !== act_v) begin
            stop_run($sformatf("** Error [%s] expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    task automatic compare_class(input string name, input drac_pkg::instr_class_e exp_v,
                                 input drac_pkg::instr_class_e act_v);
        if (exp_v !== act_v) begin
            stop_run($sformatf("** Error [%s] expected %s actual %s", name, exp_v.name(),
                               act_v.name()));
        end
    endtask

    task automatic compare_decode(input string name, input drac_pkg::decode_out_t exp_v,
                                  input drac_pkg::decode_out_t act_v);
        if (exp_v !== act_v) begin
            stop_run($sformatf("** Error [%s] expected %h actual %h", name, exp_v, act_v));
        end
    endtask

    function automatic drac_pkg::instr_class_e ref_class(input logic [31:0] w);
        drac_pkg::instr_class_e c;
        case (w[6:0])
            drac_pkg::OP_LUI, drac_pkg::OP_AUIPC: c = drac_pkg::CLASS_UPPER;
            drac_pkg::OP_JAL, drac_pkg::OP_JALR:  c = drac_pkg::CLASS_JUMP;
            drac_pkg::OP_BRANCH:                  c = drac_pkg::CLASS_BRANCH;
            drac_pkg::OP_LOAD:                    c = drac_pkg::CLASS_LOAD;
            drac_pkg::OP_STORE:                   c = drac_pkg::CLASS_STORE;
            drac_pkg::OP_ALU_I, drac_pkg::OP_ALU_I_W,
            drac_pkg::OP_ALU, drac_pkg::OP_ALU_W: c = drac_pkg::CLASS_ALU;
            drac_pkg::OP_SYSTEM: begin
                // PRIV and the reserved funct3 fall back to ALU
                c = (w[13:12] == 2'b00) ? drac_pkg::CLASS_ALU : drac_pkg::CLASS_CSR;
            end
            default: c = drac_pkg::CLASS_ILLEGAL;
        endcase
        return c;
    endfunction

    function automatic drac_pkg::decode_out_t expect_decode(input drac_pkg::bus64_t pc,
                                                            input logic [31:0] w);
        drac_pkg::decode_out_t d;
        d.pc     = pc;
        d.instr  = w;
        d.iclass = ref_class(w);
        d.rd     = w[11:7];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.imm    = ref_imm(w);
        return d;
    endfunction

    task automatic send_word(input logic [31:0] w);
        instr_valid = 1'b1;
        instr       = w;
        step();
        instr_valid = 1'b0;
    endtask

    task automatic wait_decode(input string name, output drac_pkg::decode_out_t got);
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            step();
            if (dec_valid) begin
                got = dec;
                return;
            end
        end
        stop_run($sformatf("[%s] no decoded instruction came out before the timeout", name));
    endtask

    task automatic wait_full(input string name);
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            if (full) begin
                return;
            end
            step();
        end
        stop_run($sformatf("[%s] the queue never reported full before the timeout", name));
    endtask

    // After a JAL the fetch PC jumps, and strobes in the redirect cycle are lost
    task automatic follow_jump(input drac_pkg::decode_out_t d);
        if (d.instr.common.opcode == drac_pkg::OP_JAL) begin
            exp_pc = d.pc + d.imm;
            step();
        end
    endtask

    // Sends one word into an idle front end and expects its result one cycle after the strobe
    task automatic check_one(input string name, input logic [31:0] w);
        drac_pkg::decode_out_t exp_dec;
        exp_dec = expect_decode(exp_pc, w);
        send_word(w);
        exp_pc = exp_pc + 64'd4;
        compare_bus64({name, " early"}, 64'd0, {63'd0, dec_valid});
        step();
        compare_bus64({name, " latency"}, 64'd1, {63'd0, dec_valid});
        compare_decode(name, exp_dec, dec);
        follow_jump(exp_dec);
    endtask

    task automatic test_reset();
        compare_bus64("reset dec_valid", 64'd0, {63'd0, dec_valid});
        compare_bus64("reset full", 64'd0, {63'd0, full});
        check_one("reset first", enc_i(drac_pkg::OP_ALU_I, 5'd1, 3'd0, 5'd0, 12'h001));
        compare_bus64("reset pc", drac_pkg::RESET_PC, dec.pc);
    endtask

    task automatic test_immediates();
        logic [6:0] op;
        for (int k = 0; k < 2; k++) begin
            case (lfsr_bits(2))
                0:       op = drac_pkg::OP_LOAD;
                1:       op = drac_pkg::OP_ALU_I;
                2:       op = drac_pkg::OP_JALR;
                default: op = drac_pkg::OP_ALU_I_W;
            endcase
            check_one("imm I", enc_i(op, 5'(lfsr_bits(5)), 3'(lfsr_bits(3)),
                                     5'(lfsr_bits(5)), 12'(lfsr_bits(12))));
            check_one("imm S", enc_s(3'(lfsr_bits(3)), 5'(lfsr_bits(5)), 5'(lfsr_bits(5)),
                                     12'(lfsr_bits(12))));
            check_one("imm B", enc_b(3'(lfsr_bits(3)), 5'(lfsr_bits(5)), 5'(lfsr_bits(5)),
                                     13'(lfsr_bits(13))));
            op = lfsr_bits(1) == 32'd1 ? drac_pkg::OP_LUI : drac_pkg::OP_AUIPC;
            check_one("imm U", enc_u(op, 5'(lfsr_bits(5)), 20'(lfsr_bits(20))));
            check_one("imm J", enc_j(5'(lfsr_bits(5)), 21'(lfsr_bits(21))));
        end
    endtask

    task automatic test_csr();
        check_one("csrrwi", enc_i(drac_pkg::OP_SYSTEM, 5'd3, drac_pkg::F3_CSRRWI, 5'd21,
                                  12'h300));
        compare_bus64("csrrwi imm", 64'd21, dec.imm);
        check_one("csrrsi", enc_i(drac_pkg::OP_SYSTEM, 5'd4, drac_pkg::F3_CSRRSI, 5'd31,
                                  12'h341));
        check_one("csrrci", enc_i(drac_pkg::OP_SYSTEM, 5'd5, drac_pkg::F3_CSRRCI, 5'd9,
                                  12'hfff));
        check_one("csrrw", enc_i(drac_pkg::OP_SYSTEM, 5'd6, drac_pkg::F3_CSRRW, 5'd7, 12'h305));
        // PRIV funct3 with nonzero rs1 and imm fields still gives a zero immediate
        check_one("ecall type", enc_i(drac_pkg::OP_SYSTEM, 5'd0, drac_pkg::F3_PRIV, 5'd13,
                                      12'h105));
        check_one("unknown opcode", 32'hfff0_500b);  // custom-0 space
        compare_class("unknown class", drac_pkg::CLASS_ILLEGAL, dec.iclass);
    endtask

    task automatic test_stall();
        drac_pkg::decode_out_t got;
        drac_pkg::bus64_t      base;
        logic [31:0]           words [4];
        base  = exp_pc;
        stall = 1'b1;
        for (int k = 0; k < 4; k++) begin
            words[k] = enc_i(drac_pkg::OP_ALU_I, 5'(k + 1), 3'd0, 5'd2, 12'(k * 16));
            send_word(words[k]);
            exp_pc = exp_pc + 64'd4;
        end
        wait_full("stall full");
        compare_bus64("stall no output", 64'd0, {63'd0, dec_valid});
        send_word(enc_i(drac_pkg::OP_ALU_I, 5'd30, 3'd0, 5'd0, 12'h7ff));  // Refused while full
        stall = 1'b0;
        for (int k = 0; k < 4; k++) begin
            wait_decode("stall drain", got);
            compare_decode("stall drain", expect_decode(base + 64'(4 * k), words[k]), got);
        end
        step();
        compare_bus64("stall fifth dropped", 64'd0, {63'd0, dec_valid});
        check_one("stall next", enc_i(drac_pkg::OP_ALU_I, 5'd8, 3'd0, 5'd1, 12'h010));
    endtask

    task automatic test_jal();
        drac_pkg::decode_out_t got;
        drac_pkg::decode_out_t exp_dec;
        logic [31:0]           jal;
        jal     = enc_j(5'd1, 21'(lfsr_bits(21)));
        exp_dec = expect_decode(exp_pc, jal);
        stall   = 1'b1;  // Park the JAL with its three followers in the queue
        send_word(jal);
        for (int k = 0; k < 3; k++) begin
            send_word(enc_i(drac_pkg::OP_ALU_I, 5'(k + 10), 3'd0, 5'd0, 12'h0ff));
        end
        wait_full("jal queued");
        stall = 1'b0;
        wait_decode("jal", got);
        compare_decode("jal", exp_dec, got);
        follow_jump(exp_dec);
        for (int k = 0; k < 4; k++) begin
            compare_bus64("jal followers flushed", 64'd0, {63'd0, dec_valid});
            step();
        end
        check_one("jal target", enc_i(drac_pkg::OP_ALU_I, 5'd5, 3'd0, 5'd6, 12'h123));
        compare_bus64("jal target pc", exp_dec.pc + exp_dec.imm, dec.pc);
    endtask

    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        arst_n      = 1'b0;
        exp_pc      = drac_pkg::RESET_PC;
        repeat (3) @(posedge clk);
        #5;
        arst_n = 1'b1;
        test_reset();
        test_immediates();
        test_csr();
        test_stall();
        test_jal();
        $display("sim passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+verification
src/drac_pkg.sv
src/fetch_stage.sv
src/instr_queue.sv
src/immediate.sv
src/decode_stage.sv
src/frontend_top.sv
verification/tb_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Builds the front end testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --top-module tb_frontend -f list.f -o sim_frontend > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_frontend > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
